//--- project.f
common/drnn_pkg.sv
common/dma_pkg.sv
verilog/cfg_regs.sv
ieu/delta_encoder.sv
verilog/sync_fifo.sv
verilog/cmd_gen.sv
hpc/mac_array.sv
verilog/edgedrnn_top.sv
bench/edgedrnn_assertions.sv
bench/edgedrnn_tb.sv

//--- Makefile
# Verilator build and run for the delta network front end

VERILATOR ?= verilator
TOP       ?= edgedrnn_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/edgedrnn_tb.sv
`timescale 1ns/1ns

module edgedrnn_tb
    import drnn_pkg::*, dma_pkg::*;
();

    localparam int NUM_PE         = 8;
    localparam int NZL_FIFO_DEPTH = 32;
    localparam int NUM_FRAMES     = 40;
    localparam int FRAME_TIMEOUT  = 2000;
    localparam int ACT_MAX        = 2 ** (ACT_BW - 1) - 1;
    localparam int ACT_MIN        = -(2 ** (ACT_BW - 1));

    logic                   clk;
    logic                   reset_i;
    logic                   cfg_we_i;
    logic [CFG_ADDR_BW-1:0] cfg_addr_i;
    logic [CFG_BW-1:0]      cfg_wdata_i;
    logic [CFG_BW-1:0]      cfg_rdata_o;
    logic                   in_valid_i;
    logic                   in_ready_o;
    act_t [NUM_PE-1:0]      in_data_i;
    logic                   cmd_valid_o;
    logic                   cmd_ready_i;
    dma_cmd_t               cmd_data_o;
    logic                   w_valid_i;
    logic                   w_ready_o;
    w_t [NUM_PE-1:0]        w_data_i;
    logic                   out_valid_o;
    act_t [NUM_PE-1:0]      out_data_o;

    // Reference model state
    act_t                   prev_m [NUM_PE];
    int                     acc_m [NUM_PE];
    int                     exp_idx [$];
    int                     exp_delta [$];
    logic [NUM_PE*W_BW-1:0] w_queue [$];
    logic [CFG_BW-1:0]      w_base;
    logic [CFG_BW-1:0]      col_bytes;

    int errors;
    int tests_run;
    int tests_failed;

    edgedrnn_top #(
        .NUM_PE         (NUM_PE),
        .NZL_FIFO_DEPTH (NZL_FIFO_DEPTH)
    ) dut (.*);

    bind edgedrnn_top edgedrnn_assertions u_assertions (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_o),
        .cmd_ready_i (cmd_ready_i),
        .cmd_data_i  (cmd_data_o),
        .fifo_push_i (fifo_push),
        .fifo_full_i (fifo_full),
        .w_ready_i   (w_ready_o),
        .out_valid_i (out_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // Checks and report
    // --------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[test %0d] %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("[test %0d] %s: FAILED with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    // --------------------
    // Register port
    // --------------------
    task automatic cfg_write(input logic [CFG_ADDR_BW-1:0] addr, input logic [CFG_BW-1:0] data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i    <= 1'b0;
    endtask

    // Readback register loads one edge after the address
    task automatic cfg_read(input logic [CFG_ADDR_BW-1:0] addr, output logic [CFG_BW-1:0] data);
        @(posedge clk);
        cfg_addr_i <= addr;
        @(posedge clk);
        @(negedge clk);
        data = cfg_rdata_o;
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic act_t expected_out(input int acc);
        int scaled;
        scaled = acc >>> W_FRA_BW;
        if (scaled > ACT_MAX) begin
            scaled = ACT_MAX;
        end else if (scaled < ACT_MIN) begin
            scaled = ACT_MIN;
        end
        return act_t'(scaled);
    endfunction

    // Quiet frames keep every change below the threshold
    task automatic make_frame(input int thresh, input bit quiet, output act_t [NUM_PE-1:0] vec);
        int step;
        int value;
        int diff;
        for (int p = 0; p < NUM_PE; p++) begin
            if (quiet || $urandom_range(1, 0) == 0) begin
                step  = int'($urandom_range(2 * thresh - 2, 0)) - (thresh - 1);
                value = int'(prev_m[p]) + step;
                if (value > ACT_MAX || value < ACT_MIN) begin
                    value = int'(prev_m[p]) - step;
                end
                vec[p] = act_t'(value);
            end else begin
                vec[p] = act_t'($urandom);
            end
            diff = int'(vec[p]) - int'(prev_m[p]);
            if ((diff < 0 ? -diff : diff) >= thresh) begin
                exp_idx.push_back(p);
                exp_delta.push_back(diff);
                prev_m[p] = vec[p];
            end
        end
    endtask

    task automatic check_descriptor(input dma_cmd_t cmd, input int idx);
        logic [CFG_BW-1:0] saddr;
        saddr = w_base + CFG_BW'(idx) * col_bytes;
        check_value("cmd_data_o.saddr", saddr, cmd.saddr);
        check_value("cmd_data_o.btt", col_bytes[22:0], cmd.btt);
        check_value("cmd_data_o.burst_type", 1, cmd.burst_type);
        check_value("cmd_data_o.dsa", 0, cmd.dsa);
        check_value("cmd_data_o.eof", 1, cmd.eof);
        check_value("cmd_data_o.drr", 0, cmd.drr);
        check_value("cmd_data_o.tag", 6, cmd.tag);
        check_value("cmd_data_o.rsvd", 0, cmd.rsvd);
        check_value("cmd_data_o.user", 4'hf, cmd.user);
        check_value("cmd_data_o.cache", 2, cmd.cache);
    endtask

    // --------------------
    // One frame
    // --------------------
    task automatic run_frame(input bit stall, input bit quiet);
        act_t [NUM_PE-1:0]      vec;
        logic [NUM_PE*W_BW-1:0] wcol;
        int                     thresh;
        int                     cycles;
        int                     delta;
        bit                     in_xfer;
        bit                     w_xfer;
        bit                     done;
        thresh = $urandom_range(600, 1);
        cfg_write(CFG_ADDR_THRESH, CFG_BW'(thresh));
        make_frame(thresh, quiet, vec);
        @(posedge clk);
        in_valid_i <= 1'b1;
        in_data_i  <= vec;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            // Sampled mid-cycle ahead of the rising edge that makes the transfers
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                $display("Timeout: frame did not finish within %0d cycles", FRAME_TIMEOUT);
                $display("tests failed");
                $finish;
            end
            in_xfer = in_valid_i && in_ready_o;
            w_xfer  = w_valid_i && w_ready_o;
            if (cmd_valid_o && cmd_ready_i) begin
                if (exp_idx.size() == 0) begin
                    report_failure("descriptor issued with no nonzero left in the frame");
                end else begin
                    delta = exp_delta.pop_front();
                    check_descriptor(cmd_data_o, exp_idx.pop_front());
                    wcol = {$urandom, $urandom};
                    w_queue.push_back(wcol);
                    for (int p = 0; p < NUM_PE; p++) begin
                        acc_m[p] = acc_m[p] + delta * int'(w_t'(wcol[p*W_BW +: W_BW]));
                    end
                end
            end
            if (w_xfer) begin
                void'(w_queue.pop_front());
            end
            if (out_valid_o) begin
                done = 1'b1;
                if (exp_idx.size() != 0) begin
                    report_failure("frame ended with descriptors still missing");
                end
                if (w_queue.size() != 0) begin
                    report_failure("frame ended before all weight beats were taken");
                end
                // Encoder is idle again once the frame result is out
                check_value("in_ready_o", 1, in_ready_o);
                for (int p = 0; p < NUM_PE; p++) begin
                    check_value($sformatf("out_data_o[%0d]", p), expected_out(acc_m[p]),
                                out_data_o[p]);
                end
            end else begin
                @(posedge clk);
                if (in_xfer) begin
                    in_valid_i <= 1'b0;
                end
                cmd_ready_i <= stall ? 1'($urandom_range(1, 0)) : 1'b1;
                // Weight beats follow descriptor order with one beat per descriptor
                if (!w_valid_i || w_xfer) begin
                    if (w_queue.size() != 0 && (!stall || $urandom_range(2, 0) != 0)) begin
                        w_valid_i <= 1'b1;
                        w_data_i  <= w_queue[0];
                    end else begin
                        w_valid_i <= 1'b0;
                    end
                end
            end
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_cfg_readback();
        logic [CFG_BW-1:0] wval [3];
        logic [CFG_BW-1:0] rval;
        int                errors_before;
        errors_before = errors;
        for (int a = 0; a < 3; a++) begin
            wval[a] = $urandom;
            cfg_write(CFG_ADDR_BW'(a), wval[a]);
        end
        for (int a = 0; a < 3; a++) begin
            cfg_read(CFG_ADDR_BW'(a), rval);
            check_value($sformatf("cfg_rdata_o[addr %0d]", a), wval[a], rval);
        end
        cfg_read(CFG_ADDR_BW'(3), rval);
        check_value("cfg_rdata_o[addr 3]", 0, rval);
        finish_test("register readback", errors_before);
    endtask

    task automatic test_frames(input string name, input bit stall);
        int errors_before;
        bit quiet;
        errors_before = errors;
        w_base    = $urandom & 32'hffff_ff00;
        col_bytes = CFG_BW'($urandom_range(64, 1) * 16);
        cfg_write(CFG_ADDR_W_BASE, w_base);
        cfg_write(CFG_ADDR_COL_BYTES, col_bytes);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            quiet = (f % 8 == 3) || ($urandom_range(5, 0) == 0);
            run_frame(stall, quiet);
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        void'($urandom(27));
        reset_i     = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        cmd_ready_i = 1'b1;
        w_valid_i   = 1'b0;
        w_data_i    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int p = 0; p < NUM_PE; p++) begin
            prev_m[p] = '0;
            acc_m[p]  = 0;
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        test_cfg_readback();
        test_frames("random frames, no back-pressure", 1'b0);
        test_frames("random frames, random stalls", 1'b1);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- bench/edgedrnn_assertions.sv
`timescale 1ns/1ns

module edgedrnn_assertions
    import dma_pkg::*;
(
    input logic     clk,
    input logic     reset_i,
    input logic     cmd_valid_i,
    input logic     cmd_ready_i,
    input dma_cmd_t cmd_data_i,
    input logic     fifo_push_i,
    input logic     fifo_full_i,
    input logic     w_ready_i,
    input logic     out_valid_i
);

    // Descriptor waits for the datamover
    cmd_hold: assert property (@(posedge clk) disable iff (reset_i)
        cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_data_i))
        else $error("descriptor dropped or changed before cmd_ready");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset_i)
        !(fifo_push_i && fifo_full_i))
        else $error("delta pushed into a full FIFO");

    out_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_i |=> !out_valid_i)
        else $error("out_valid high for two cycles in a row");

    // Outputs settle after the first reset edge
    quiet_in_reset: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !out_valid_i && !cmd_valid_i && !w_ready_i)
        else $error("handshake output active during reset");

endmodule

//--- verilog/edgedrnn_top.sv
`timescale 1ns/1ns

module edgedrnn_top
    import drnn_pkg::*, dma_pkg::*;
#(
    parameter int NUM_PE         = 8,
    parameter int NZL_FIFO_DEPTH = 32
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cfg_we_i,
    input  logic [CFG_ADDR_BW-1:0] cfg_addr_i,
    input  logic [CFG_BW-1:0]      cfg_wdata_i,
    output logic [CFG_BW-1:0]      cfg_rdata_o,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  act_t [NUM_PE-1:0]      in_data_i,
    output logic                   cmd_valid_o,
    input  logic                   cmd_ready_i,
    output dma_cmd_t               cmd_data_o,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  w_t [NUM_PE-1:0]        w_data_i,
    output logic                   out_valid_o,
    output act_t [NUM_PE-1:0]      out_data_o
);

    // Configuration
    logic [CFG_BW-1:0] thresh;
    logic [CFG_BW-1:0] w_base;
    logic [CFG_BW-1:0] col_bytes;

    // Nonzero stream
    logic   nz_valid;
    logic   nz_ready;
    nz_t    nz_data;
    logic   scan_done;

    // Delta FIFO
    logic   fifo_push;
    delta_t fifo_push_data;
    logic   fifo_pop;
    delta_t fifo_pop_data;
    logic   fifo_full;
    logic   fifo_empty;

    // --------------------
    // Instances
    // --------------------
    cfg_regs i_cfg_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .thresh_o    (thresh),
        .w_base_o    (w_base),
        .col_bytes_o (col_bytes)
    );

    delta_encoder #(
        .NUM_PE (NUM_PE)
    ) i_delta_encoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .thresh_i    (thresh),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .nz_valid_o  (nz_valid),
        .nz_ready_i  (nz_ready),
        .nz_data_o   (nz_data),
        .scan_done_o (scan_done)
    );

    cmd_gen i_cmd_gen (
        .clk         (clk),
        .reset_i     (reset_i),
        .w_base_i    (w_base),
        .col_bytes_i (col_bytes),
        .nz_valid_i  (nz_valid),
        .nz_ready_o  (nz_ready),
        .nz_data_i   (nz_data),
        .fifo_full_i (fifo_full),
        .push_o      (fifo_push),
        .push_data_o (fifo_push_data),
        .cmd_valid_o (cmd_valid_o),
        .cmd_ready_i (cmd_ready_i),
        .cmd_data_o  (cmd_data_o)
    );

    sync_fifo #(
        .payload_t (delta_t),
        .DEPTH     (NZL_FIFO_DEPTH)
    ) i_nzl_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_pop_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    mac_array #(
        .NUM_PE (NUM_PE)
    ) i_mac_array (
        .clk          (clk),
        .reset_i      (reset_i),
        .scan_done_i  (scan_done),
        .fifo_data_i  (fifo_pop_data),
        .fifo_empty_i (fifo_empty),
        .pop_o        (fifo_pop),
        .w_valid_i    (w_valid_i),
        .w_ready_o    (w_ready_o),
        .w_data_i     (w_data_i),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o)
    );

endmodule

//--- hpc/mac_array.sv
`timescale 1ns/1ns

module mac_array
    import drnn_pkg::*;
#(
    parameter int NUM_PE = 8
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              scan_done_i,
    input  delta_t            fifo_data_i,
    input  logic              fifo_empty_i,
    output logic              pop_o,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    input  w_t [NUM_PE-1:0]   w_data_i,
    output logic              out_valid_o,
    output act_t [NUM_PE-1:0] out_data_o
);

    localparam acc_t ACT_MAX = (acc_t'(1) <<< (ACT_BW - 1)) - 1;
    localparam acc_t ACT_MIN = -(acc_t'(1) <<< (ACT_BW - 1));

    logic pending_q;
    logic beat;

    // One weight beat consumes one queued delta
    assign w_ready_o = !fifo_empty_i;
    assign beat      = w_valid_i && w_ready_o;
    assign pop_o     = beat;

    // --------------------
    // Frame completion
    // --------------------
    assign out_valid_o = pending_q && fifo_empty_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (scan_done_i) begin
            pending_q <= 1'b1;
        end else if (out_valid_o) begin
            pending_q <= 1'b0;
        end
    end

    // --------------------
    // Processing elements
    // --------------------
    for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
        acc_t acc_q;
        acc_t prod;
        acc_t scaled;

        assign prod = acc_t'(fifo_data_i) * acc_t'(w_data_i[p]);

        // Accumulators carry over from frame to frame
        always_ff @(posedge clk) begin
            if (reset_i) begin
                acc_q <= '0;
            end else if (beat) begin
                acc_q <= acc_q + prod;
            end
        end

        // Drop the weight fraction bits, then clamp to activation range
        assign scaled = acc_q >>> W_FRA_BW;

        always_comb begin
            if (scaled > ACT_MAX) begin
                out_data_o[p] = act_t'(ACT_MAX);
            end else if (scaled < ACT_MIN) begin
                out_data_o[p] = act_t'(ACT_MIN);
            end else begin
                out_data_o[p] = act_t'(scaled);
            end
        end
    end

endmodule

//--- verilog/cmd_gen.sv
`timescale 1ns/1ns

module cmd_gen
    import drnn_pkg::*, dma_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic [CFG_BW-1:0] w_base_i,
    input  logic [CFG_BW-1:0] col_bytes_i,
    input  logic              nz_valid_i,
    output logic              nz_ready_o,
    input  nz_t               nz_data_i,
    input  logic              fifo_full_i,
    output logic              push_o,
    output delta_t            push_data_o,
    output logic              cmd_valid_o,
    input  logic              cmd_ready_i,
    output dma_cmd_t          cmd_data_o
);

    logic     accept;
    dma_cmd_t cmd_next;

    // Descriptor slot is free or draining this cycle
    assign nz_ready_o  = (!cmd_valid_o || cmd_ready_i) && !fifo_full_i;
    assign accept      = nz_valid_i && nz_ready_o;

    // Delta goes to the FIFO in the acceptance cycle
    assign push_o      = accept;
    assign push_data_o = nz_data_i.delta;

    // --------------------
    // Descriptor fields
    // --------------------
    always_comb begin
        cmd_next            = '0;
        cmd_next.btt        = col_bytes_i[22:0];
        cmd_next.burst_type = CMD_BURST_INCR;
        cmd_next.dsa        = CMD_DSA;
        cmd_next.eof        = CMD_EOF;
        cmd_next.drr        = CMD_DRR;
        cmd_next.saddr      = w_base_i + CFG_BW'(nz_data_i.idx) * col_bytes_i;
        cmd_next.tag        = CMD_TAG;
        cmd_next.rsvd       = CMD_RSVD;
        cmd_next.user       = CMD_USER;
        cmd_next.cache      = CMD_CACHE;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_valid_o <= 1'b0;
        end else if (accept) begin
            cmd_valid_o <= 1'b1;
        end else if (cmd_ready_i) begin
            cmd_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_data_o <= cmd_next;
        end
    end

endmodule

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BW = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_BW-1:0]   wr_ptr_q;
    logic [PTR_BW-1:0]   rd_ptr_q;
    logic [CNT_BW-1:0]   count_q;
    logic                do_push;
    logic                do_pop;

    assign full_o     = count_q == CNT_BW'(DEPTH);
    assign empty_o    = count_q == '0;
    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && !empty_o;

    // Head entry is visible without read latency
    assign pop_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

//--- ieu/delta_encoder.sv
`timescale 1ns/1ns

module delta_encoder
    import drnn_pkg::*, dma_pkg::*;
#(
    parameter int NUM_PE = 8
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [CFG_BW-1:0]       thresh_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  act_t [NUM_PE-1:0]       in_data_i,
    output logic                    nz_valid_o,
    input  logic                    nz_ready_i,
    output nz_t                     nz_data_o,
    output logic                    scan_done_o
);

    localparam int IDX_BW = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_DONE
    } state_t;

    state_t              state_q;
    logic [IDX_BW-1:0]   idx_q;
    act_t [NUM_PE-1:0]   cur_q;
    act_t [NUM_PE-1:0]   prev_q;

    delta_t              diff;
    logic [ACT_BW:0]     mag;
    logic                hit;
    logic                last;
    logic                step;

    // --------------------
    // Element compare
    // --------------------
    assign diff = delta_t'(cur_q[idx_q]) - delta_t'(prev_q[idx_q]);
    assign mag  = diff[ACT_BW] ? -diff : diff;
    assign hit  = CFG_BW'(mag) >= thresh_i;
    assign last = idx_q == IDX_BW'(NUM_PE - 1);

    // Skipped elements advance at once, hits wait for the handshake
    assign step = !hit || nz_ready_i;

    assign in_ready_o      = state_q == S_IDLE;
    assign scan_done_o     = state_q == S_DONE;
    assign nz_valid_o      = (state_q == S_SCAN) && hit;
    assign nz_data_o.idx   = NZI_BW'(idx_q);
    assign nz_data_o.delta = diff;

    // --------------------
    // Scan control
    // --------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            prev_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (in_valid_i) begin
                        state_q <= S_SCAN;
                        idx_q   <= '0;
                    end
                end
                S_SCAN: begin
                    if (step) begin
                        if (last) begin
                            state_q <= S_DONE;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase

            // Remember the value that was actually sent
            if (nz_valid_o && nz_ready_i) begin
                prev_q[idx_q] <= cur_q[idx_q];
            end
        end
    end

    // Vector capture
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            cur_q <= in_data_i;
        end
    end

endmodule

//--- verilog/cfg_regs.sv
`timescale 1ns/1ns

module cfg_regs
    import dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cfg_we_i,
    input  logic [CFG_ADDR_BW-1:0] cfg_addr_i,
    input  logic [CFG_BW-1:0]      cfg_wdata_i,
    output logic [CFG_BW-1:0]      cfg_rdata_o,
    output logic [CFG_BW-1:0]      thresh_o,
    output logic [CFG_BW-1:0]      w_base_o,
    output logic [CFG_BW-1:0]      col_bytes_o
);

    // Register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            thresh_o    <= '0;
            w_base_o    <= '0;
            col_bytes_o <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_ADDR_THRESH:    thresh_o    <= cfg_wdata_i;
                CFG_ADDR_W_BASE:    w_base_o    <= cfg_wdata_i;
                CFG_ADDR_COL_BYTES: col_bytes_o <= cfg_wdata_i;
                default: ;
            endcase
        end
    end

    // Readback lags the address by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_rdata_o <= '0;
        end else begin
            case (cfg_addr_i)
                CFG_ADDR_THRESH:    cfg_rdata_o <= thresh_o;
                CFG_ADDR_W_BASE:    cfg_rdata_o <= w_base_o;
                CFG_ADDR_COL_BYTES: cfg_rdata_o <= col_bytes_o;
                default:            cfg_rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- common/dma_pkg.sv
package dma_pkg;

    // --------------------
    // Datamover command
    // --------------------
    typedef struct packed {
        logic [3:0]  cache;
        logic [3:0]  user;
        logic [3:0]  rsvd;
        logic [3:0]  tag;
        logic [31:0] saddr;
        logic        drr;
        logic        eof;
        logic [5:0]  dsa;
        logic        burst_type;
        logic [22:0] btt;
    } dma_cmd_t;

    // Fixed descriptor fields
    localparam logic       CMD_BURST_INCR = 1'b1;
    localparam logic [5:0] CMD_DSA        = 6'd0;
    localparam logic       CMD_EOF        = 1'b1;
    localparam logic       CMD_DRR        = 1'b0;
    localparam logic [3:0] CMD_TAG        = 4'd6;
    localparam logic [3:0] CMD_RSVD       = 4'd0;
    localparam logic [3:0] CMD_USER       = 4'hf;
    localparam logic [3:0] CMD_CACHE      = 4'd2;

    // --------------------
    // Configuration map
    // --------------------
    localparam int CFG_BW      = 32;
    localparam int CFG_ADDR_BW = 2;

    localparam logic [CFG_ADDR_BW-1:0] CFG_ADDR_THRESH    = 2'd0;
    localparam logic [CFG_ADDR_BW-1:0] CFG_ADDR_W_BASE    = 2'd1;
    localparam logic [CFG_ADDR_BW-1:0] CFG_ADDR_COL_BYTES = 2'd2;

endpackage

//--- common/drnn_pkg.sv
package drnn_pkg;

    // --------------------
    // Fixed-point formats
    // --------------------
    localparam int ACT_INT_BW = 8;
    localparam int ACT_FRA_BW = 8;
    localparam int W_INT_BW   = 1;
    localparam int W_FRA_BW   = 7;

    localparam int ACT_BW = ACT_INT_BW + ACT_FRA_BW;
    localparam int W_BW   = W_INT_BW + W_FRA_BW;
    localparam int ACC_BW = 32;

    // Nonzero index width
    localparam int NZI_BW = 16;

    // --------------------
    // Data types
    // --------------------
    typedef logic signed [ACT_BW-1:0] act_t;
    typedef logic signed [W_BW-1:0]   w_t;

    // One extra bit so the difference of two activations never overflows
    typedef logic signed [ACT_BW:0]   delta_t;

    // Wrapping accumulator
    typedef logic signed [ACC_BW-1:0] acc_t;

    typedef struct packed {
        logic [NZI_BW-1:0] idx;
        delta_t            delta;
    } nz_t;

endpackage
